/* vlog.f */
+incdir+include
rtl/dispatch_pkg.sv
rtl/general_register_file.sv
rtl/system_register_file.sv
rtl/operand_select.sv
rtl/dispatch_latch.sv
rtl/dispatch.sv
test/tb_dispatch.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_dispatch
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/tb_dispatch_tasks.svh */
`ifndef TB_DISPATCH_TASKS_SVH
`define TB_DISPATCH_TASKS_SVH

task automatic idle_inputs();
	previous_valid = 1'b0;
	previous_inst = '0;
	wb = '0;
	pipeline_stop = 1'b0;
	refresh = 1'b0;
	irq_set = 1'b0;
	irq_clear = 1'b0;
	next_lock = 1'b0;
endtask

// Valid instruction with random pc, cmd and destination
task automatic present_inst(
	input dispatch_pkg::reg_index_t src0,
	input logic src0_sys,
	input dispatch_pkg::data_t src1,
	input logic src1_sys,
	input logic src1_imm,
	input dispatch_pkg::exec_unit_t unit
);
	previous_valid = 1'b1;
	previous_inst = '0;
	previous_inst.source0 = src0;
	previous_inst.source0_active = 1'b1;
	previous_inst.source0_sysreg = src0_sys;
	previous_inst.source1 = src1;
	previous_inst.source1_active = 1'b1;
	previous_inst.source1_sysreg = src1_sys;
	previous_inst.source1_imm = src1_imm;
	previous_inst.destination = rand_index();
	previous_inst.writeback = 1'b1;
	previous_inst.cmd = dispatch_pkg::cmd_t'(next_rand() >> 3);
	previous_inst.exec_unit = unit;
	previous_inst.pc = next_rand() & 32'hffff_fffc;
endtask

task automatic retire_result(
	input dispatch_pkg::reg_index_t dest,
	input logic dest_sys,
	input dispatch_pkg::data_t data
);
	wb = '0;
	wb.valid = 1'b1;
	wb.writeback = 1'b1;
	wb.destination = dest;
	wb.destination_sysreg = dest_sys;
	wb.data = data;
	wb.spr = next_rand();
	wb.pc = next_rand() & 32'hffff_fffc;
	wb.branch = (next_rand() & 32'h100) != 32'h0;
	wb.branch_pc = next_rand() & 32'hffff_fffc;
endtask

// Random writes each read back by the next dispatch
task automatic register_file_test();
	dispatch_pkg::reg_index_t idx;
	for (int i = 0; i < NUM_RANDOM; i++) begin
		idx = rand_index();
		idle_inputs();
		retire_result(idx, 1'b0, next_rand());
		pipeline_stop = (next_rand() & 32'h3) == 32'h0;
		cycle();
		idle_inputs();
		present_inst(idx, 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
		cycle();
	end
endtask

task automatic forwarding_test();
	dispatch_pkg::reg_index_t idx;
	idx = rand_index();
	idle_inputs();
	retire_result(idx, 1'b0, next_rand());
	present_inst(idx, 1'b0, dispatch_pkg::data_t'(idx), 1'b0, 1'b0, ADDER_UNIT);
	cycle();
	// Immediate whose low bits hit the write-back target
	idle_inputs();
	retire_result(idx, 1'b0, next_rand());
	present_inst(idx, 1'b0, (next_rand() & 32'hffff_ffe0) | dispatch_pkg::data_t'(idx),
		1'b0, 1'b1, ADDER_UNIT);
	cycle();
	idle_inputs();
	retire_result(dispatch_pkg::SYSREG_TIDR, 1'b1, next_rand());
	wb.spr_writeback = 1'b1;
	present_inst(dispatch_pkg::SYSREG_SPR, 1'b1, dispatch_pkg::data_t'(dispatch_pkg::SYSREG_PCR),
		1'b1, 1'b0, ADDER_UNIT);
	cycle();
	idle_inputs();
	retire_result(dispatch_pkg::SYSREG_TIDR, 1'b1, next_rand());
	present_inst(dispatch_pkg::SYSREG_TIDR, 1'b1, dispatch_pkg::data_t'(dispatch_pkg::SYSREG_PSR),
		1'b1, 1'b0, ADDER_UNIT);
	cycle();
endtask

task automatic sysreg_test();
	idle_inputs();
	retire_result(dispatch_pkg::SYSREG_TIDR, 1'b1, next_rand());
	cycle();
	idle_inputs();
	retire_result(dispatch_pkg::SYSREG_SPR, 1'b1, next_rand());
	cycle();
	// Dedicated SPR path together with a data write to SPR
	idle_inputs();
	retire_result(dispatch_pkg::SYSREG_SPR, 1'b1, next_rand());
	wb.spr_writeback = 1'b1;
	cycle();
	idle_inputs();
	present_inst(dispatch_pkg::SYSREG_COREIDR, 1'b1,
		dispatch_pkg::data_t'(dispatch_pkg::SYSREG_PCR), 1'b1, 1'b0, ADDER_UNIT);
	cycle();
	idle_inputs();
	present_inst(dispatch_pkg::SYSREG_TIDR, 1'b1, 32'd17, 1'b1, 1'b0, ADDER_UNIT);
	cycle();
endtask

task automatic irq_test();
	idle_inputs();
	retire_result(dispatch_pkg::SYSREG_PSR, 1'b1, next_rand() | 32'h64);
	cycle();
	idle_inputs();
	irq_set = 1'b1;
	cycle();
	idle_inputs();
	retire_result(dispatch_pkg::SYSREG_PSR, 1'b1, next_rand());
	cycle();
	idle_inputs();
	present_inst(dispatch_pkg::SYSREG_PPSR, 1'b1,
		dispatch_pkg::data_t'(dispatch_pkg::SYSREG_PSR), 1'b1, 1'b0, ADDER_UNIT);
	cycle();
	idle_inputs();
	irq_clear = 1'b1;
	cycle();
endtask

task automatic lock_refresh_test();
	idle_inputs();
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
	cycle();
	// Previous stage keeps its instruction while locked
	idle_inputs();
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
	next_lock = 1'b1;
	repeat (3) cycle();
	next_lock = 1'b0;
	cycle();
	idle_inputs();
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
	refresh = 1'b1;
	cycle();
	// Nothing has retired since the flush
	idle_inputs();
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
	cycle();
endtask

task automatic branch_lock_test();
	idle_inputs();
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, BRANCH_UNIT);
	cycle();
	idle_inputs();
	retire_result(rand_index(), 1'b0, next_rand());
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
	cycle();
	idle_inputs();
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, BRANCH_UNIT);
	cycle();
	idle_inputs();
	present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
	cycle();
endtask

`endif

/* test/tb_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dispatch;

	localparam dispatch_pkg::data_t CORE_ID = 32'h0000_0003;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_RANDOM = 32;
	// Two cycles per random write and read pair plus room for the directed tests
	localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * NUM_RANDOM + 40;
	localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;
	localparam dispatch_pkg::exec_unit_t ADDER_UNIT = 10'h010;
	localparam dispatch_pkg::exec_unit_t BRANCH_UNIT =
		dispatch_pkg::exec_unit_t'(1 << dispatch_pkg::EXEC_BRANCH_BIT);

	logic iCLOCK;
	logic inRESET;
	logic pipeline_stop;
	logic refresh;
	logic irq_set;
	logic irq_clear;
	logic previous_valid;
	dispatch_pkg::dispatch_inst_t previous_inst;
	logic previous_lock;
	logic next_valid;
	dispatch_pkg::issue_t next_issue;
	logic next_lock;
	dispatch_pkg::writeback_t wb;
	logic exception_lock;
	dispatch_pkg::sysreg_view_t sysreg_view;

	// Shadow state of the stage
	dispatch_pkg::data_t gr_shadow [0:31];
	dispatch_pkg::sysreg_view_t sr_shadow;
	logic pcr_ok;
	logic exp_valid;
	dispatch_pkg::issue_t exp_issue;

	logic [31:0] rng_state;
	int cycles = 0;
	int fail_count = 0;

	dispatch #(.CORE_ID(CORE_ID)) DUT (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.pipeline_stop(pipeline_stop), .refresh(refresh),
		.irq_set(irq_set), .irq_clear(irq_clear),
		.previous_valid(previous_valid), .previous_inst(previous_inst),
		.previous_lock(previous_lock),
		.next_valid(next_valid), .next_issue(next_issue), .next_lock(next_lock),
		.wb(wb), .exception_lock(exception_lock), .sysreg_view(sysreg_view)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #20 iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic dispatch_pkg::reg_index_t rand_index();
		return dispatch_pkg::reg_index_t'(next_rand() >> 11);
	endfunction

	task automatic report_mismatch(input string what);
		fail_count++;
		$display("ERROR: %s", what);
		$display("Simulation FAILED");
		$fatal(1, "check failed");
	endtask

	`include "tb_dispatch_tasks.svh"

	// Value a system register read should return
	function automatic dispatch_pkg::data_t sysreg_value(input dispatch_pkg::reg_index_t index);
		case (index)
			dispatch_pkg::SYSREG_SPR: return sr_shadow.spr;
			dispatch_pkg::SYSREG_PSR: return sr_shadow.psr;
			dispatch_pkg::SYSREG_PCR: return previous_inst.pc - dispatch_pkg::PC_STEP;
			dispatch_pkg::SYSREG_TIDR: return sr_shadow.tidr;
			dispatch_pkg::SYSREG_PPSR: return sr_shadow.ppsr;
			dispatch_pkg::SYSREG_COREIDR: return CORE_ID;
			default: return '0;
		endcase
	endfunction

	// Forwarded result before the register files
	function automatic dispatch_pkg::data_t expected_operand(
		input dispatch_pkg::reg_index_t index,
		input logic sysreg,
		input logic active
	);
		if (wb.valid && sysreg && wb.destination_sysreg) begin
			if (index == dispatch_pkg::SYSREG_PCR) begin
				return wb.pc;
			end
			if (index == dispatch_pkg::SYSREG_SPR && wb.spr_writeback) begin
				return wb.spr;
			end
		end
		if (wb.valid && wb.writeback && index == wb.destination &&
			sysreg == wb.destination_sysreg) begin
			return wb.data;
		end
		if (active && sysreg) begin
			return sysreg_value(index);
		end
		return gr_shadow[index];
	endfunction

	function automatic dispatch_pkg::issue_t expected_issue();
		dispatch_pkg::issue_t e;
		e.source0 = expected_operand(previous_inst.source0, previous_inst.source0_sysreg,
			previous_inst.source0_active);
		if (previous_inst.source1_imm) begin
			e.source1 = previous_inst.source1;
		end else begin
			e.source1 = expected_operand(previous_inst.source1[4:0],
				previous_inst.source1_sysreg, previous_inst.source1_active);
		end
		e.source0_pointer = previous_inst.source0;
		e.source1_pointer = previous_inst.source1[4:0];
		e.source0_sysreg = previous_inst.source0_sysreg;
		e.source1_sysreg = previous_inst.source1_sysreg;
		e.source1_imm = previous_inst.source1_imm;
		e.destination = previous_inst.destination;
		e.destination_sysreg = previous_inst.destination_sysreg;
		e.writeback = previous_inst.writeback;
		e.cmd = previous_inst.cmd;
		e.exec_unit = previous_inst.exec_unit;
		e.pc = previous_inst.pc;
		return e;
	endfunction

	// Register writes seen at the last edge
	task automatic update_shadow();
		dispatch_pkg::sysreg_view_t old;
		logic retire;
		logic sys_write;
		old = sr_shadow;
		retire = wb.valid && !pipeline_stop;
		sys_write = retire && wb.writeback && wb.destination_sysreg;
		if (retire && wb.writeback && !wb.destination_sysreg) begin
			gr_shadow[wb.destination] = wb.data;
		end
		if (irq_set) begin
			sr_shadow.psr = old.psr & dispatch_pkg::PSR_IRQ_CLEAR_MASK;
			sr_shadow.ppsr = old.psr;
		end else if (irq_clear) begin
			sr_shadow.psr = old.ppsr;
		end else if (sys_write && wb.destination == dispatch_pkg::SYSREG_PSR) begin
			sr_shadow.psr = wb.data;
		end
		if (!irq_set && sys_write && wb.destination == dispatch_pkg::SYSREG_PPSR) begin
			sr_shadow.ppsr = wb.data;
		end
		if (sys_write && wb.destination == dispatch_pkg::SYSREG_TIDR) begin
			sr_shadow.tidr = wb.data;
		end
		if (retire && wb.spr_writeback) begin
			sr_shadow.spr = wb.spr;
		end else if (sys_write && wb.destination == dispatch_pkg::SYSREG_SPR) begin
			sr_shadow.spr = wb.data;
		end
		if (retire) begin
			sr_shadow.pcr = wb.branch ? wb.branch_pc : wb.pc;
		end
		if (refresh) begin
			pcr_ok = 1'b0;
		end else if (retire) begin
			pcr_ok = 1'b1;
		end
	endtask

	task automatic check_outputs();
		logic exp_next_valid;
		logic exp_lock;
		exp_next_valid = exp_valid && !next_lock;
		exp_lock = !pcr_ok || !exp_valid || exp_issue.exec_unit[dispatch_pkg::EXEC_BRANCH_BIT];
		assert (next_valid === exp_next_valid) else report_mismatch(
			$sformatf("next_valid = %h, expected %h", next_valid, exp_next_valid));
		assert (previous_lock === next_lock) else report_mismatch(
			$sformatf("previous_lock = %h, expected %h", previous_lock, next_lock));
		assert (next_issue === exp_issue) else report_mismatch(
			$sformatf("next_issue = %h, expected %h", next_issue, exp_issue));
		assert (sysreg_view === sr_shadow) else report_mismatch(
			$sformatf("sysreg_view = %h, expected %h", sysreg_view, sr_shadow));
		assert (exception_lock === exp_lock) else report_mismatch(
			$sformatf("exception_lock = %h, expected %h", exception_lock, exp_lock));
	endtask

	// Clock edge followed by model update and checks
	task automatic cycle();
		dispatch_pkg::issue_t pending;
		pending = expected_issue();
		@(posedge iCLOCK);
		#2;
		if (refresh) begin
			exp_valid = 1'b0;
			exp_issue = '0;
		end else if (!next_lock) begin
			exp_valid = previous_valid;
			exp_issue = pending;
		end
		update_shadow();
		check_outputs();
	endtask

	initial begin
		rng_state = 32'hd782;
		inRESET = 1'b0;
		idle_inputs();
		for (int i = 0; i < 32; i++) begin
			gr_shadow[i] = '0;
		end
		sr_shadow = '0;
		pcr_ok = 1'b0;
		exp_valid = 1'b0;
		exp_issue = '0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
		// Valid instruction before anything has retired
		present_inst(rand_index(), 1'b0, dispatch_pkg::data_t'(rand_index()), 1'b0, 1'b0, ADDER_UNIT);
		cycle();
		register_file_test();
		forwarding_test();
		sysreg_test();
		irq_test();
		lock_refresh_test();
		branch_lock_test();
		idle_inputs();
		cycle();
		if (fail_count == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("Simulation FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

/* rtl/dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch #(
	parameter dispatch_pkg::data_t CORE_ID = 32'h0
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire pipeline_stop,
	input wire refresh,
	input wire irq_set,
	input wire irq_clear,
	input wire previous_valid,
	input wire dispatch_pkg::dispatch_inst_t previous_inst,
	output logic previous_lock,
	output logic next_valid,
	output dispatch_pkg::issue_t next_issue,
	input wire next_lock,
	input wire dispatch_pkg::writeback_t wb,
	output logic exception_lock,
	output dispatch_pkg::sysreg_view_t sysreg_view
);

	dispatch_pkg::reg_index_t gr_index0;
	dispatch_pkg::reg_index_t gr_index1;
	dispatch_pkg::reg_index_t sr_index0;
	dispatch_pkg::reg_index_t sr_index1;
	dispatch_pkg::data_t gr_data0;
	dispatch_pkg::data_t gr_data1;
	dispatch_pkg::data_t sr_data0;
	dispatch_pkg::data_t sr_data1;
	dispatch_pkg::data_t source0;
	dispatch_pkg::data_t source1;
	logic pcr_valid;

	general_register_file u_gr (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.pipeline_stop(pipeline_stop), .wb(wb),
		.read_index0(gr_index0), .read_index1(gr_index1),
		.read_data0(gr_data0), .read_data1(gr_data1)
	);

	system_register_file #(.CORE_ID(CORE_ID)) u_sr (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.pipeline_stop(pipeline_stop), .refresh(refresh),
		.irq_set(irq_set), .irq_clear(irq_clear), .wb(wb),
		.read_index0(sr_index0), .read_index1(sr_index1),
		.read_pc(previous_inst.pc),
		.read_data0(sr_data0), .read_data1(sr_data1),
		.pcr_valid(pcr_valid), .sysreg_view(sysreg_view)
	);

	operand_select u_sel (
		.wb(wb), .previous_inst(previous_inst),
		.gr_index0(gr_index0), .gr_index1(gr_index1),
		.sr_index0(sr_index0), .sr_index1(sr_index1),
		.gr_data0(gr_data0), .gr_data1(gr_data1),
		.sr_data0(sr_data0), .sr_data1(sr_data1),
		.source0(source0), .source1(source1)
	);

	dispatch_latch u_latch (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .refresh(refresh),
		.previous_valid(previous_valid), .previous_inst(previous_inst),
		.source0(source0), .source1(source1),
		.next_lock(next_lock), .pcr_valid(pcr_valid),
		.previous_lock(previous_lock), .next_valid(next_valid),
		.next_issue(next_issue), .exception_lock(exception_lock)
	);

endmodule

`default_nettype wire

/* rtl/dispatch_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_latch (
	input wire iCLOCK,
	input wire inRESET,
	input wire refresh,
	input wire previous_valid,
	input wire dispatch_pkg::dispatch_inst_t previous_inst,
	input wire dispatch_pkg::data_t source0,
	input wire dispatch_pkg::data_t source1,
	input wire next_lock,
	input wire pcr_valid,
	output logic previous_lock,
	output logic next_valid,
	output dispatch_pkg::issue_t next_issue,
	output logic exception_lock
);

	logic valid_r;
	dispatch_pkg::issue_t issue_r;
	dispatch_pkg::issue_t captured;

	always_comb begin
		captured.source0 = source0;
		captured.source1 = source1;
		captured.source0_pointer = previous_inst.source0;
		captured.source1_pointer = previous_inst.source1[4:0];
		captured.source0_sysreg = previous_inst.source0_sysreg;
		captured.source1_sysreg = previous_inst.source1_sysreg;
		captured.source1_imm = previous_inst.source1_imm;
		captured.destination = previous_inst.destination;
		captured.destination_sysreg = previous_inst.destination_sysreg;
		captured.writeback = previous_inst.writeback;
		captured.cmd = previous_inst.cmd;
		captured.exec_unit = previous_inst.exec_unit;
		captured.pc = previous_inst.pc;
	end

	// Refresh flushes, lock holds
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_r <= 1'b0;
			issue_r <= '0;
		end else if (refresh) begin
			valid_r <= 1'b0;
			issue_r <= '0;
		end else if (!next_lock) begin
			valid_r <= previous_valid;
			issue_r <= captured;
		end
	end

	// No stall source here, back-pressure passes straight up
	assign previous_lock = next_lock;
	assign next_valid = valid_r && !next_lock;
	assign next_issue = issue_r;

	assign exception_lock = !pcr_valid || !valid_r ||
		issue_r.exec_unit[dispatch_pkg::EXEC_BRANCH_BIT];

endmodule

`default_nettype wire

/* rtl/operand_select.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_select (
	input wire dispatch_pkg::writeback_t wb,
	input wire dispatch_pkg::dispatch_inst_t previous_inst,
	output dispatch_pkg::reg_index_t gr_index0,
	output dispatch_pkg::reg_index_t gr_index1,
	output dispatch_pkg::reg_index_t sr_index0,
	output dispatch_pkg::reg_index_t sr_index1,
	input wire dispatch_pkg::data_t gr_data0,
	input wire dispatch_pkg::data_t gr_data1,
	input wire dispatch_pkg::data_t sr_data0,
	input wire dispatch_pkg::data_t sr_data1,
	output dispatch_pkg::data_t source0,
	output dispatch_pkg::data_t source1
);

	typedef struct packed {
		logic hit;
		dispatch_pkg::data_t data;
	} forward_t;

	forward_t fwd0;
	forward_t fwd1;

	// Write-back value seen by a source in the same cycle
	function automatic forward_t forward(
		input dispatch_pkg::reg_index_t index,
		input logic sysreg,
		input dispatch_pkg::writeback_t w
	);
		forward_t f;
		f = '0;
		if (w.valid && sysreg && w.destination_sysreg) begin
			if (index == dispatch_pkg::SYSREG_PCR) begin
				f = '{hit: 1'b1, data: w.pc};
			end else if (index == dispatch_pkg::SYSREG_SPR && w.spr_writeback) begin
				f = '{hit: 1'b1, data: w.spr};
			end else if (index == w.destination && w.writeback) begin
				f = '{hit: 1'b1, data: w.data};
			end
		end else if (w.valid && !sysreg && !w.destination_sysreg) begin
			if (index == w.destination && w.writeback) begin
				f = '{hit: 1'b1, data: w.data};
			end
		end
		return f;
	endfunction

	// Both files see the same pointers
	assign gr_index0 = previous_inst.source0;
	assign gr_index1 = previous_inst.source1[4:0];
	assign sr_index0 = previous_inst.source0;
	assign sr_index1 = previous_inst.source1[4:0];

	always_comb begin
		fwd0 = forward(previous_inst.source0, previous_inst.source0_sysreg, wb);
		fwd1 = forward(previous_inst.source1[4:0], previous_inst.source1_sysreg, wb);

		if (fwd0.hit) begin
			source0 = fwd0.data;
		end else if (previous_inst.source0_active && previous_inst.source0_sysreg) begin
			source0 = sr_data0;
		end else begin
			source0 = gr_data0;
		end

		// Immediate wins even over a matching write-back
		if (previous_inst.source1_imm) begin
			source1 = previous_inst.source1;
		end else if (fwd1.hit) begin
			source1 = fwd1.data;
		end else if (previous_inst.source1_active && previous_inst.source1_sysreg) begin
			source1 = sr_data1;
		end else begin
			source1 = gr_data1;
		end
	end

endmodule

`default_nettype wire

/* rtl/system_register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module system_register_file #(
	parameter dispatch_pkg::data_t CORE_ID = 32'h0
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire pipeline_stop,
	input wire refresh,
	input wire irq_set,
	input wire irq_clear,
	input wire dispatch_pkg::writeback_t wb,
	input wire dispatch_pkg::reg_index_t read_index0,
	input wire dispatch_pkg::reg_index_t read_index1,
	input wire dispatch_pkg::data_t read_pc,
	output dispatch_pkg::data_t read_data0,
	output dispatch_pkg::data_t read_data1,
	output logic pcr_valid,
	output dispatch_pkg::sysreg_view_t sysreg_view
);

	dispatch_pkg::sysreg_view_t regs;
	logic retire;
	logic sys_write;
	logic spr_write;

	assign retire = wb.valid && !pipeline_stop;
	assign sys_write = retire && wb.writeback && wb.destination_sysreg;
	assign spr_write = retire && wb.spr_writeback;

	function automatic dispatch_pkg::data_t sysreg_read(
		input dispatch_pkg::reg_index_t index,
		input dispatch_pkg::sysreg_view_t view,
		input dispatch_pkg::data_t pc
	);
		case (index)
			dispatch_pkg::SYSREG_SPR: return view.spr;
			dispatch_pkg::SYSREG_PSR: return view.psr;
			// PC of the instruction before the reader
			dispatch_pkg::SYSREG_PCR: return pc - dispatch_pkg::PC_STEP;
			dispatch_pkg::SYSREG_TIDR: return view.tidr;
			dispatch_pkg::SYSREG_PPSR: return view.ppsr;
			dispatch_pkg::SYSREG_COREIDR: return CORE_ID;
			default: return '0;
		endcase
	endfunction

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			regs <= '0;
		end else begin
			// IRQ entry saves PSR and drops the enables, exit restores it
			if (irq_set) begin
				regs.psr <= regs.psr & dispatch_pkg::PSR_IRQ_CLEAR_MASK;
				regs.ppsr <= regs.psr;
			end else if (irq_clear) begin
				regs.psr <= regs.ppsr;
			end else if (sys_write && wb.destination == dispatch_pkg::SYSREG_PSR) begin
				regs.psr <= wb.data;
			end

			if (!irq_set && sys_write && wb.destination == dispatch_pkg::SYSREG_PPSR) begin
				regs.ppsr <= wb.data;
			end

			if (sys_write && wb.destination == dispatch_pkg::SYSREG_TIDR) begin
				regs.tidr <= wb.data;
			end

			// Dedicated SPR path beats a data write
			if (spr_write) begin
				regs.spr <= wb.spr;
			end else if (sys_write && wb.destination == dispatch_pkg::SYSREG_SPR) begin
				regs.spr <= wb.data;
			end

			if (retire) begin
				regs.pcr <= wb.branch ? wb.branch_pc : wb.pc;
			end
		end
	end

	// PCR holds a real value once something has retired
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr_valid <= 1'b0;
		end else if (refresh) begin
			pcr_valid <= 1'b0;
		end else if (retire) begin
			pcr_valid <= 1'b1;
		end
	end

	always_comb begin
		read_data0 = sysreg_read(read_index0, regs, read_pc);
		read_data1 = sysreg_read(read_index1, regs, read_pc);
	end

	assign sysreg_view = regs;

endmodule

`default_nettype wire

/* rtl/general_register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module general_register_file (
	input wire iCLOCK,
	input wire inRESET,
	input wire pipeline_stop,
	input wire dispatch_pkg::writeback_t wb,
	input wire dispatch_pkg::reg_index_t read_index0,
	input wire dispatch_pkg::reg_index_t read_index1,
	output dispatch_pkg::data_t read_data0,
	output dispatch_pkg::data_t read_data1
);

	dispatch_pkg::data_t regs [0:31];
	logic write_en;

	// Only retiring results aimed at a general register
	assign write_en = wb.valid && wb.writeback && !wb.destination_sysreg && !pipeline_stop;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	// Asynchronous reads, old value in the write cycle
	assign read_data0 = regs[read_index0];
	assign read_data1 = regs[read_index1];

endmodule

`default_nettype wire

/* rtl/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

	typedef logic [31:0] data_t;
	typedef logic [4:0] reg_index_t;
	typedef logic [4:0] cmd_t;

	// One-hot, bit 0 upward: sys_reg, sys_ldst, logic, shift, adder,
	// mul, sdiv, udiv, ldst, branch
	typedef logic [9:0] exec_unit_t;

	localparam int EXEC_BRANCH_BIT = 9;

	// System register numbers
	localparam reg_index_t SYSREG_SPR = 5'd0;
	localparam reg_index_t SYSREG_PSR = 5'd1;
	localparam reg_index_t SYSREG_PCR = 5'd2;
	localparam reg_index_t SYSREG_TIDR = 5'd3;
	localparam reg_index_t SYSREG_PPSR = 5'd4;
	localparam reg_index_t SYSREG_COREIDR = 5'd5;

	// Interrupt enables live at PSR bits 6, 5 and 2
	localparam data_t PSR_IRQ_CLEAR_MASK = 32'hffff_ff9b;

	localparam data_t PC_STEP = 32'd4;

	typedef struct packed {
		reg_index_t source0;
		logic source0_active;
		logic source0_sysreg;
		data_t source1;
		logic source1_active;
		logic source1_sysreg;
		logic source1_imm;
		reg_index_t destination;
		logic destination_sysreg;
		logic writeback;
		cmd_t cmd;
		exec_unit_t exec_unit;
		data_t pc;
	} dispatch_inst_t;

	typedef struct packed {
		logic valid;
		data_t data;
		reg_index_t destination;
		logic destination_sysreg;
		logic writeback;
		logic spr_writeback;
		data_t spr;
		data_t pc;
		logic branch;
		data_t branch_pc;
	} writeback_t;

	typedef struct packed {
		data_t source0;
		data_t source1;
		reg_index_t source0_pointer;
		reg_index_t source1_pointer;
		logic source0_sysreg;
		logic source1_sysreg;
		logic source1_imm;
		reg_index_t destination;
		logic destination_sysreg;
		logic writeback;
		cmd_t cmd;
		exec_unit_t exec_unit;
		data_t pc;
	} issue_t;

	typedef struct packed {
		data_t psr;
		data_t ppsr;
		data_t tidr;
		data_t spr;
		data_t pcr;
	} sysreg_view_t;

endpackage

`default_nettype wire
